// ==== bufferPkg.sv ====
//------------------------------
// Receive buffer geometry
// Word width and count widths
//------------------------------
`default_nettype none

package bufferPkg;

  //------------------------------
  // Buffer sizing
  //------------------------------
  localparam int bufferLog2  = 3;                    // Log2 of slot count
  localparam int bufferDepth = 1 << bufferLog2;      // Slots and initial credits
  localparam int wordWidth   = 8;                    // Bits per data word
  localparam int countWidth  = bufferLog2 + 1;       // Holds 0 to bufferDepth

endpackage : bufferPkg

`default_nettype wire

// ==== linkPkg.sv ====
//------------------------------
// Link command and sender state types
// Channel latency
//------------------------------
`default_nettype none

package linkPkg;

  localparam int linkLatency = 2;                    // Stages per channel direction

  //------------------------------
  // Producer commands
  //------------------------------
  typedef enum logic [1:0] {
    opIdle  = 2'd0,                                  // No action
    opPush  = 2'd1,                                  // Send one word
    opClear = 2'd2                                   // Flush link and buffer
  } linkOp;

  //------------------------------
  // Sender FSM
  //------------------------------
  typedef enum logic [1:0] {
    stateReset  = 2'd0,                              // Credits still zero
    stateActive = 2'd1,                              // Normal operation
    stateFlush  = 2'd2                               // Clearing link
  } senderState;

endpackage : linkPkg

`default_nettype wire

// ==== circularBuffer.sv ====
//------------------------------
// Receive FIFO on a circular store
// Clear, push, pop and occupancy counts
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module circularBuffer
  import bufferPkg::*;
(
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  clear,           // Empty the store
  input  logic                  inEnable,        // Write request
  input  logic [wordWidth-1:0]  in,              // Incoming word
  input  logic                  pop,             // Read request
  output logic [wordWidth-1:0]  out,             // Last popped word
  output logic                  popDone,         // A pop took effect this cycle
  output logic [countWidth-1:0] inRemainder,     // Free slots
  output logic [countWidth-1:0] outRemainder     // Words readable
);

  logic [wordWidth-1:0]  store [bufferDepth];    // Word slots
  logic [bufferLog2-1:0] readPos;                // Oldest word
  logic [bufferLog2-1:0] writePos;               // Next free slot
  logic [countWidth-1:0] fillCount;              // Words held
  logic                  full;
  logic                  empty;
  logic                  doWrite;
  logic                  doRead;

  //------------------------------
  // Occupancy
  //------------------------------
  assign full         = (fillCount == countWidth'(bufferDepth));
  assign empty        = (fillCount == '0);
  assign doWrite      = inEnable && !full && !clear;   // Counter makes every slot usable
  assign doRead       = pop && !empty && !clear;
  assign popDone      = doRead;                        // Drives credit return
  assign outRemainder = fillCount;
  assign inRemainder  = countWidth'(bufferDepth) - fillCount;

  //------------------------------
  // Pointers and fill count
  //------------------------------
  always_ff @(posedge clock) begin
    if (reset || clear) begin
      readPos   <= '0;                           // Drop everything
      writePos  <= '0;
      fillCount <= '0;
    end else begin
      if (doWrite) writePos <= writePos + 1'b1;   // Wraps at depth
      if (doRead)  readPos  <= readPos + 1'b1;
      case ({doWrite, doRead})
        2'b10:   fillCount <= fillCount + 1'b1;
        2'b01:   fillCount <= fillCount - 1'b1;
        default: fillCount <= fillCount;         // Both or neither
      endcase
    end
  end

  // Slot storage
  always_ff @(posedge clock) begin
    if (doWrite) store[writePos] <= in;
  end

  // Output word holds until the next pop
  always_ff @(posedge clock) begin
    if (reset) begin
      out <= '0;
    end else if (doRead) begin
      out <= store[readPos];
    end
  end

endmodule : circularBuffer

`default_nettype wire

// ==== linkChannel.sv ====
//------------------------------
// Fixed-latency wire model
// Forward data and reverse credits
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module linkChannel
  import bufferPkg::*;
  import linkPkg::*;
(
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 clear,            // Drop all in-flight items
  input  logic                 sendValid,        // Word entering the wire
  input  logic [wordWidth-1:0] sendData,
  output logic                 recvValid,        // Word leaving the wire
  output logic [wordWidth-1:0] recvData,
  input  logic                 creditIn,         // Credit pulse from receiver
  output logic                 creditOut         // Credit pulse at sender
);

  logic                 validPipe  [linkLatency];  // Forward valid stages
  logic [wordWidth-1:0] dataPipe   [linkLatency];  // Forward payload stages
  logic                 creditPipe [linkLatency];  // Reverse pulse stages

  //------------------------------
  // Control stages
  //------------------------------
  always_ff @(posedge clock) begin
    if (reset || clear) begin
      for (int i = 0; i < linkLatency; i++) begin
        validPipe[i]  <= 1'b0;
        creditPipe[i] <= 1'b0;
      end
    end else begin
      validPipe[0]  <= sendValid;                // Stage 1 takes the launch
      creditPipe[0] <= creditIn;
      for (int i = 1; i < linkLatency; i++) begin
        validPipe[i]  <= validPipe[i-1];         // Several items in flight
        creditPipe[i] <= creditPipe[i-1];
      end
    end
  end

  // Payload follows its valid bit
  always_ff @(posedge clock) begin
    dataPipe[0] <= sendData;
    for (int i = 1; i < linkLatency; i++) dataPipe[i] <= dataPipe[i-1];
  end

  assign recvValid = validPipe[linkLatency-1];
  assign recvData  = dataPipe[linkLatency-1];
  assign creditOut = creditPipe[linkLatency-1];

endmodule : linkChannel

`default_nettype wire

// ==== creditSender.sv ====
//------------------------------
// Producer command decoder
// Credit counter and flush FSM
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module creditSender
  import bufferPkg::*;
  import linkPkg::*;
(
  input  logic                  clock,
  input  logic                  reset,
  input  linkOp                 op,              // Producer command
  input  logic [wordWidth-1:0]  data,            // Word to push
  input  logic                  creditReturn,    // Pulse from channel
  output logic                  sendValid,       // Launch into channel
  output logic [wordWidth-1:0]  sendData,
  output logic                  clear,           // Flush channel and buffer
  output logic [countWidth-1:0] credits          // Send credits held
);

  senderState                       state;
  logic [$clog2(linkLatency):0]     flushCount;  // Flush cycles left
  logic                             accept;

  //------------------------------
  // Push decode
  //------------------------------
  assign accept    = (state == stateActive) && (op == opPush) && (credits != '0);
  assign sendValid = accept;                     // Captured by channel stage 1
  assign sendData  = data;
  assign clear     = (state == stateFlush);

  //------------------------------
  // FSM and credit counter
  //------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      state      <= stateReset;
      credits    <= '0;                          // No credits until active
      flushCount <= '0;
    end else begin
      case (state)
        stateReset: begin
          state   <= stateActive;
          credits <= countWidth'(bufferDepth);   // One per buffer slot
        end
        stateActive: begin
          if (op == opClear) begin
            state      <= stateFlush;
            flushCount <= ($clog2(linkLatency) + 1)'(linkLatency - 1);
          end else begin
            case ({accept, creditReturn})
              2'b10:   credits <= credits - 1'b1;  // Spend on push
              2'b01:   credits <= credits + 1'b1;  // Refund on pop
              default: credits <= credits;         // Push and refund cancel
            endcase
          end
        end
        stateFlush: begin
          if (flushCount == '0) begin
            state   <= stateActive;
            credits <= countWidth'(bufferDepth);   // Link and buffer now empty
          end else begin
            flushCount <= flushCount - 1'b1;
          end
        end
        default: state <= stateReset;
      endcase
    end
  end

endmodule : creditSender

`default_nettype wire

// ==== linkTop.sv ====
//------------------------------
// Credit link top level
// Sender, channel and receive buffer
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module linkTop
  import bufferPkg::*;
  import linkPkg::*;
(
  input  logic                  clock,
  input  logic                  reset,
  input  linkOp                 op,              // Producer command
  input  logic [wordWidth-1:0]  data,            // Producer word
  input  logic                  pop,             // Consumer remove request
  output logic [countWidth-1:0] credits,         // Send credits available
  output logic [wordWidth-1:0]  out,             // Last popped word
  output logic [countWidth-1:0] inRemainder,     // Free slots
  output logic [countWidth-1:0] outRemainder     // Words readable
);

  //------------------------------
  // Internal wires
  //------------------------------
  logic                 sendValid;
  logic [wordWidth-1:0] sendData;
  logic                 recvValid;
  logic [wordWidth-1:0] recvData;
  logic                 clear;
  logic                 popDone;                 // Credit launched back
  logic                 creditOut;               // Credit arriving at sender

  creditSender sender_i (
    .clock        (clock),
    .reset        (reset),
    .op           (op),
    .data         (data),
    .creditReturn (creditOut),
    .sendValid    (sendValid),
    .sendData     (sendData),
    .clear        (clear),
    .credits      (credits)
  );

  linkChannel channel_i (
    .clock     (clock),
    .reset     (reset),
    .clear     (clear),
    .sendValid (sendValid),
    .sendData  (sendData),
    .recvValid (recvValid),
    .recvData  (recvData),
    .creditIn  (popDone),
    .creditOut (creditOut)
  );

  circularBuffer buffer_i (
    .clock        (clock),
    .reset        (reset),
    .clear        (clear),
    .inEnable     (recvValid),                   // Credits guarantee room
    .in           (recvData),
    .pop          (pop),
    .out          (out),
    .popDone      (popDone),
    .inRemainder  (inRemainder),
    .outRemainder (outRemainder)
  );

endmodule : linkTop

`default_nettype wire

// ==== linkChecker_checker.sv ====
//------------------------------
// Bound assertions on the link
// Credit, occupancy and flush rules
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module linkChecker
  import bufferPkg::*;
  import linkPkg::*;
(
  input logic                  clock,
  input logic                  reset,
  input logic [countWidth-1:0] credits,
  input logic [countWidth-1:0] inRemainder,
  input logic [countWidth-1:0] outRemainder,
  input logic                  recvValid,      // Word arriving at the buffer
  input logic                  clear,
  input senderState            state
);

  creditsBounded: assert property (@(posedge clock) disable iff (reset)
    credits <= countWidth'(bufferDepth)) else $error("credits above buffer depth");

  // Held words and spare credits never outnumber the slots
  fillBounded: assert property (@(posedge clock) disable iff (reset)
    int'(credits) + int'(outRemainder) <= bufferDepth)
    else $error("fill plus credits above buffer depth");

  // Credits must leave room for every arriving word
  roomOnArrival: assert property (@(posedge clock) disable iff (reset)
    recvValid |-> inRemainder != '0) else $error("word arrived at a full buffer");

  // Flush ends active, empty and with every credit back
  clearInFlush: assert property (@(posedge clock) disable iff (reset)
    $fell(clear) |-> state == stateActive && credits == countWidth'(bufferDepth)
                     && outRemainder == '0)
    else $error("flush did not end empty with full credits");

endmodule : linkChecker

bind linkTop linkChecker checker_i (
  .clock        (clock),
  .reset        (reset),
  .credits      (credits),
  .inRemainder  (inRemainder),
  .outRemainder (outRemainder),
  .recvValid    (recvValid),
  .clear        (clear),
  .state        (sender_i.state)
);

`default_nettype wire

// ==== linkTb.sv ====
//------------------------------
// Testbench for the credit link
// File-driven stimulus, queue model
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module linkTb
  import bufferPkg::*;
  import linkPkg::*;
();

  localparam int resetCycles  = 10;
  localparam int waitLimit    = 50;              // Cycles a pop or flush may wait
  localparam int settleCycles = linkLatency + 2; // Both directions drained

  logic                  clock = 1'b0;
  logic                  reset;
  linkOp                 op;
  logic [wordWidth-1:0]  data;
  logic                  pop;
  logic [countWidth-1:0] credits;
  logic [wordWidth-1:0]  out;
  logic [countWidth-1:0] inRemainder;
  logic [countWidth-1:0] outRemainder;

  string                testName [$];           // One entry per script line
  string                testCmd  [$];
  logic [wordWidth-1:0] testData [$];
  logic [wordWidth-1:0] testExp  [$];
  logic [wordWidth-1:0] model    [$];           // Accepted words not yet popped
  int                   numTests = 0;
  int                   errors   = 0;
  int                   checks   = 0;
  int                   seed     = 21324;
  bit                   loaded   = 1'b0;

  always #5 clock = ~clock;

  linkTop dut_i (
    .clock        (clock),
    .reset        (reset),
    .op           (op),
    .data         (data),
    .pop          (pop),
    .credits      (credits),
    .out          (out),
    .inRemainder  (inRemainder),
    .outRemainder (outRemainder)
  );

  //------------------------------
  // Check helpers
  //------------------------------
  task automatic checkValue(input string name, input logic [wordWidth-1:0] expected,
                            input logic [wordWidth-1:0] actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("Error: test %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic driveIdle();
    @(posedge clock);
    op  <= opIdle;
    pop <= 1'b0;
  endtask

  //------------------------------
  // Commands
  //------------------------------
  task automatic sendPush(input logic [wordWidth-1:0] word);
    @(posedge clock);
    op   <= opPush;
    data <= word;
    pop  <= 1'b0;
    @(negedge clock);
    if (credits != '0) model.push_back(word);    // Sender takes it on the next edge
  endtask

  task automatic takePop(input string name, input logic [wordWidth-1:0] expected);
    int waited;
    waited = 0;
    driveIdle();
    @(negedge clock);
    while (outRemainder == '0 && waited < waitLimit) begin
      @(negedge clock);
      waited++;
    end
    assert (outRemainder != '0) else begin
      errors++;
      $display("Test %s found no word to pop after waiting %0d cycles", name, waited);
    end
    if (outRemainder != '0) begin
      @(posedge clock);
      pop <= 1'b1;
      driveIdle();                               // Buffer pops on this edge
      @(negedge clock);
      checkValue(name, expected, out);
      assert (model.size() > 0) else begin
        errors++;
        $display("Test %s popped a word the model never accepted", name);
      end
      if (model.size() > 0) checkValue(name, model.pop_front(), out);
    end
  endtask

  task automatic clearLink(input string name);
    int waited;
    waited = 0;
    @(posedge clock);
    op  <= opClear;
    pop <= 1'b0;
    driveIdle();                                 // Flush starts on this edge
    @(negedge clock);
    while (dut_i.clear && waited < waitLimit) begin
      @(negedge clock);
      waited++;
    end
    assert (!dut_i.clear) else begin
      errors++;
      $display("Test %s saw the flush never end", name);
    end
    model.delete();
    checkValue(name, '0, wordWidth'(outRemainder));
    checkValue(name, wordWidth'(bufferDepth), wordWidth'(credits));
  endtask

  task automatic settleCheck(input string name, input logic [wordWidth-1:0] expected);
    repeat (settleCycles) driveIdle();
    @(negedge clock);
    checkValue(name, expected, wordWidth'(outRemainder));
    checkValue(name, wordWidth'(model.size()), wordWidth'(outRemainder));
    checkValue(name, wordWidth'(bufferDepth), wordWidth'(credits) + wordWidth'(outRemainder));
    checkValue(name, wordWidth'(bufferDepth),
               wordWidth'(inRemainder) + wordWidth'(outRemainder));
  endtask

  //------------------------------
  // Main sequence
  //------------------------------
  initial begin
    int                   fd;
    int                   gap;
    string                line;
    string                name;
    string                cmd;
    logic [wordWidth-1:0] d;
    logic [wordWidth-1:0] e;
    reset <= 1'b1;
    op    <= opIdle;
    data  <= '0;
    pop   <= 1'b0;
    fd = $fopen("linkTests.txt", "r");
    assert (fd != 0) else begin
      errors++;
      $display("Cannot open the script linkTests.txt");
    end
    if (fd != 0) begin
      while (!$feof(fd)) begin
        if ($fgets(line, fd) != 0 && line.len() > 0 && line[0] != 8'h23) begin
          if ($sscanf(line, "%s %s %h %h", name, cmd, d, e) == 4) begin
            testName.push_back(name);
            testCmd.push_back(cmd);
            testData.push_back(d);
            testExp.push_back(e);
          end
        end
      end
      $fclose(fd);
    end
    numTests = testName.size();
    loaded   = 1'b1;                             // Arms the watchdog
    repeat (resetCycles) @(posedge clock);
    reset <= 1'b0;
    repeat (2) @(posedge clock);                 // One cycle in stateReset
    for (int i = 0; i < numTests; i++) begin
      if (testCmd[i] == "push") sendPush(testData[i]);
      else if (testCmd[i] == "pop") takePop(testName[i], testExp[i]);
      else if (testCmd[i] == "clear") clearLink(testName[i]);
      else if (testCmd[i] == "idle") settleCheck(testName[i], testExp[i]);
      else begin
        errors++;
        $display("Test %s has an unknown command %s", testName[i], testCmd[i]);
      end
      gap = $unsigned($random(seed)) % 3;        // Random idle gap
      repeat (gap) driveIdle();
    end
    driveIdle();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) $display("Test passed");
    else $display("Test failed");
    $finish;
  end

  // Watchdog sized from the script length
  initial begin
    wait (loaded);
    repeat ((numTests + 1) * 20 + resetCycles) @(posedge clock);
    $display("Timeout after %0d script lines without finishing", numTests);
    $display("Test failed");
    $finish;
  end

endmodule : linkTb

`default_nettype wire

// ==== linkTests.txt ====
# Columns: test name, command (push pop clear idle), data hex, expected hex
# Pop expects the popped word, idle expects outRemainder once the link settles
order push 11 00
order push 22 00
order pop 00 11
order pop 00 22
overrun push a0 00
overrun push a1 00
overrun push a2 00
overrun push a3 00
overrun push a4 00
overrun push a5 00
overrun push a6 00
overrun push a7 00
overrun push a8 00
overrun push a9 00
overrun push aa 00
overrun idle 00 08
drain pop 00 a0
drain pop 00 a1
drain pop 00 a2
drain pop 00 a3
drain pop 00 a4
drain pop 00 a5
drain pop 00 a6
drain pop 00 a7
creditReturn idle 00 00
clear push 5a 00
clear push 5b 00
clear clear 00 00
clear idle 00 00
fresh push c1 00
fresh pop 00 c1
fresh idle 00 00

// ==== build.f ====
bufferPkg.sv
linkPkg.sv
circularBuffer.sv
linkChannel.sv
creditSender.sv
linkTop.sv
linkChecker_checker.sv
linkTb.sv

// ==== run.sh ====
#!/bin/bash
# Compile and run the credit link testbench with Verilator
set -e -o pipefail
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module linkTb -f build.f -o linkSim
./obj_dir/linkSim 2>&1 | tee sim.log
if grep -q "Test failed" sim.log; then
  exit 1
fi
